// File: verilog/lsq_pkg.sv
package lsq_pkg;

    // slot and queue sizes
    localparam int num_fu_load = 2;
    localparam int lq_idx_bits = 1;
    localparam int sq_size     = 8;
    localparam int sq_idx_bits = 3;

    // cycles from taken request to response pulse
    localparam int mem_latency = 3;

    localparam int xlen      = 32;
    localparam int robn_bits = 5;
    localparam int prn_bits  = 6;

    // load size and signedness
    typedef enum logic [2:0] {
        mem_byte,
        mem_half,
        mem_word,
        mem_byteu,
        mem_halfu
    } mem_func_t;

    // known once data came from the store queue or from memory
    typedef enum logic {
        known,
        no_forward
    } load_state_t;

    // add stage register, feeds the store queue query
    typedef struct packed {
        logic                   valid;
        mem_func_t              func;
        logic [xlen-1:0]        addr;
        logic [prn_bits-1:0]    prn;
        logic [robn_bits-1:0]   robn;
        logic [sq_idx_bits-1:0] tail_store;
    } lu_reg_t;

    // query stage register with the forwarding answer
    typedef struct packed {
        logic                   valid;
        mem_func_t              func;
        logic [xlen-1:0]        addr;
        logic [prn_bits-1:0]    prn;
        logic [robn_bits-1:0]   robn;
        logic [sq_idx_bits-1:0] tail_store;
        logic [xlen-1:0]        value;
        logic                   fwd_valid;
    } lu_fwd_reg_t;

    // one entry per slot, waits for memory and then for the completion bus
    typedef struct packed {
        logic                 valid;
        mem_func_t            func;
        logic [xlen-1:0]      addr;
        logic [xlen-1:0]      data;
        logic [prn_bits-1:0]  prn;
        logic [robn_bits-1:0] robn;
        load_state_t          state;
    } ld_entry_t;

endpackage

// File: verilog/lsq_ifs.sv
`timescale 1ns/1ps

// one per load slot, answered combinationally by the store queue
interface sq_fwd_if;
    import lsq_pkg::*;

    logic [xlen-1:0]        addr;
    logic [sq_idx_bits-1:0] store_range;
    mem_func_t              func;
    logic [xlen-1:0]        value;
    logic                   fwd_valid;

    modport load  (output addr, store_range, func, input value, fwd_valid);
    modport store (input addr, store_range, func, output value, fwd_valid);
endinterface

// single read port to data memory
interface dcache_req_if;
    import lsq_pkg::*;

    logic                   req_valid;
    logic [lq_idx_bits-1:0] req_idx;
    logic [xlen-1:0]        req_addr;
    // level, high whenever a request can be taken
    logic                   accept;
    // one cycle pulse
    logic                   resp_valid;
    logic [lq_idx_bits-1:0] resp_idx;
    logic [xlen-1:0]        resp_data;

    modport request (output req_valid, req_idx, req_addr);
    modport memory  (input req_valid, req_idx, req_addr,
                     output accept, resp_valid, resp_idx, resp_data);
    modport listen  (input accept, resp_valid, resp_idx, resp_data);
endinterface

// File: verilog/sign_align.sv
`timescale 1ns/1ps

module sign_align (
    input  logic [lsq_pkg::xlen-1:0] data,
    input  logic [1:0]               addr,
    input  lsq_pkg::mem_func_t       func,
    output logic [lsq_pkg::xlen-1:0] out
);
    import lsq_pkg::*;

    logic [xlen-1:0] shifted;

    // addressed byte down to bit 0
    assign shifted = data >> {addr, 3'b000};

    always_comb begin
        case (func)
            mem_byte: begin
                out = {{(xlen-8){shifted[7]}}, shifted[7:0]};
            end
            mem_byteu: begin
                out = {{(xlen-8){1'b0}}, shifted[7:0]};
            end
            mem_half: begin
                out = {{(xlen-16){shifted[15]}}, shifted[15:0]};
            end
            mem_halfu: begin
                out = {{(xlen-16){1'b0}}, shifted[15:0]};
            end
            // word
            default: begin
                out = shifted;
            end
        endcase
    end

endmodule

// File: verilog/load_arbiter.sv
`timescale 1ns/1ps

module load_arbiter (
    input  logic [lsq_pkg::num_fu_load-1:0]                    need_mem,
    input  logic [lsq_pkg::num_fu_load-1:0][lsq_pkg::xlen-1:0] entry_addr,
    output logic [lsq_pkg::lq_idx_bits-1:0]                    grant_idx,
    output logic                                               grant_valid,
    dcache_req_if.request dcache
);
    import lsq_pkg::*;

    // fixed priority, slot 0 highest
    always_comb begin
        grant_valid = 1'b0;
        grant_idx   = '0;
        // scan downward so the lowest slot is written last
        for (int i = num_fu_load - 1; i >= 0; i--) begin
            if (need_mem[i]) begin
                grant_valid = 1'b1;
                grant_idx   = lq_idx_bits'(i);
            end
        end
    end

    // request from the winning slot
    assign dcache.req_valid = grant_valid;
    assign dcache.req_idx   = grant_idx;
    assign dcache.req_addr  = entry_addr[grant_idx];

endmodule

// File: verilog/store_queue.sv
`timescale 1ns/1ps

module store_queue (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            store_write,
    input  logic [lsq_pkg::sq_idx_bits-1:0] store_idx,
    input  logic [lsq_pkg::xlen-1:0]        store_addr,
    input  logic [lsq_pkg::xlen-1:0]        store_data,
    sq_fwd_if.store sq [lsq_pkg::num_fu_load]
);
    import lsq_pkg::*;

    logic [sq_size-1:0] sq_valid;
    logic [xlen-1:0]    sq_addr [sq_size];
    logic [xlen-1:0]    sq_data [sq_size];

    // written by index from outside
    always_ff @(posedge clock) begin
        if (reset) begin
            sq_valid <= '0;
        end else if (store_write) begin
            sq_valid[store_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (store_write) begin
            sq_addr[store_idx] <= store_addr;
            sq_data[store_idx] <= store_data;
        end
    end

    for (genvar g = 0; g < num_fu_load; g++) begin : fwd
        logic            hit;
        logic [xlen-1:0] word;
        logic [xlen-1:0] shifted;

        // entries below store_range are older than the load
        always_comb begin
            hit  = 1'b0;
            word = '0;
            // later match overwrites, youngest older store wins
            for (int i = 0; i < sq_size; i++) begin
                if (sq_valid[i] && sq_idx_bits'(i) < sq[g].store_range
                        && sq_addr[i][xlen-1:2] == sq[g].addr[xlen-1:2]) begin
                    hit  = 1'b1;
                    word = sq_data[i];
                end
            end
        end

        assign shifted = word >> {sq[g].addr[1:0], 3'b000};

        // only the bytes the load asks for
        always_comb begin
            case (sq[g].func)
                mem_byte, mem_byteu: begin
                    sq[g].value = {{(xlen-8){1'b0}}, shifted[7:0]};
                end
                mem_half, mem_halfu: begin
                    sq[g].value = {{(xlen-16){1'b0}}, shifted[15:0]};
                end
                default: begin
                    sq[g].value = shifted;
                end
            endcase
        end

        assign sq[g].fwd_valid = hit;
    end

endmodule

// File: verilog/data_memory.sv
`timescale 1ns/1ps

module data_memory (
    input logic clock,
    input logic reset,
    dcache_req_if.memory dcache
);
    import lsq_pkg::*;

    logic                   ready;
    logic [mem_latency-1:0] pipe_valid;
    logic [lq_idx_bits-1:0] pipe_idx  [mem_latency];
    logic [xlen-1:0]        pipe_addr [mem_latency];
    logic [15:0]            word_low;

    // always ready once out of reset
    always_ff @(posedge clock) begin
        if (reset) begin
            ready      <= 1'b0;
            pipe_valid <= '0;
        end else begin
            ready      <= 1'b1;
            pipe_valid <= {pipe_valid[mem_latency-2:0], dcache.req_valid && ready};
        end
    end

    // index and address ride along with the valid bits
    always_ff @(posedge clock) begin
        pipe_idx[0]  <= dcache.req_idx;
        pipe_addr[0] <= dcache.req_addr;
        for (int i = 1; i < mem_latency; i++) begin
            pipe_idx[i]  <= pipe_idx[i-1];
            pipe_addr[i] <= pipe_addr[i-1];
        end
    end

    assign dcache.accept     = ready;
    assign dcache.resp_valid = pipe_valid[mem_latency-1];
    assign dcache.resp_idx   = pipe_idx[mem_latency-1];

    // contents rule, inverted word address over plain word address
    assign word_low         = pipe_addr[mem_latency-1][17:2];
    assign dcache.resp_data = {~word_low, word_low};

endmodule

// File: verilog/load_queue.sv
`timescale 1ns/1ps

module load_queue (
    input  logic clock,
    input  logic reset,
    // from reservation station
    input  logic [lsq_pkg::num_fu_load-1:0]                           issue_valid,
    input  logic [lsq_pkg::num_fu_load-1:0][lsq_pkg::xlen-1:0]        issue_base,
    input  logic [lsq_pkg::num_fu_load-1:0][11:0]                     issue_offset,
    input  lsq_pkg::mem_func_t [lsq_pkg::num_fu_load-1:0]             issue_func,
    input  logic [lsq_pkg::num_fu_load-1:0][lsq_pkg::prn_bits-1:0]    issue_prn,
    input  logic [lsq_pkg::num_fu_load-1:0][lsq_pkg::robn_bits-1:0]   issue_robn,
    input  logic [lsq_pkg::num_fu_load-1:0][lsq_pkg::sq_idx_bits-1:0] issue_tail_store,
    output logic [lsq_pkg::num_fu_load-1:0]                           rs_ready,
    // completion bus
    input  logic [lsq_pkg::num_fu_load-1:0]                           cdb_grant,
    output logic [lsq_pkg::num_fu_load-1:0]                           result_valid,
    output logic [lsq_pkg::num_fu_load-1:0][lsq_pkg::robn_bits-1:0]   result_robn,
    output logic [lsq_pkg::num_fu_load-1:0][lsq_pkg::prn_bits-1:0]    result_prn,
    output logic [lsq_pkg::num_fu_load-1:0][lsq_pkg::xlen-1:0]        result_data,
    // store queue query
    sq_fwd_if.load sq [lsq_pkg::num_fu_load],
    // memory request side
    output logic [lsq_pkg::num_fu_load-1:0]                           need_mem,
    output logic [lsq_pkg::num_fu_load-1:0][lsq_pkg::xlen-1:0]        entry_addr,
    input  logic [lsq_pkg::lq_idx_bits-1:0]                           grant_idx,
    input  logic                                                      grant_valid,
    dcache_req_if.listen dcache
);
    import lsq_pkg::*;

    lu_reg_t     lu_reg     [num_fu_load];
    lu_fwd_reg_t lu_fwd_reg [num_fu_load];
    ld_entry_t   entries    [num_fu_load];

    for (genvar g = 0; g < num_fu_load; g++) begin : slot
        logic issue_take;
        logic taken;
        logic resp_hit;
        logic req_sent;

        // one load per slot in flight
        assign rs_ready[g] = !lu_reg[g].valid && !lu_fwd_reg[g].valid && !entries[g].valid;
        assign issue_take  = issue_valid[g] && rs_ready[g];

        // add stage
        always_ff @(posedge clock) begin
            if (reset) begin
                lu_reg[g].valid <= 1'b0;
            end else begin
                lu_reg[g].valid <= issue_take;
            end
            if (issue_take) begin
                lu_reg[g].func <= issue_func[g];
                // offset sign-extended as in RISC-V loads
                lu_reg[g].addr <= issue_base[g]
                    + {{(xlen-12){issue_offset[g][11]}}, issue_offset[g]};
                lu_reg[g].prn        <= issue_prn[g];
                lu_reg[g].robn       <= issue_robn[g];
                lu_reg[g].tail_store <= issue_tail_store[g];
            end
        end

        // query the store queue from the add register
        assign sq[g].addr        = lu_reg[g].addr;
        assign sq[g].store_range = lu_reg[g].tail_store;
        assign sq[g].func        = lu_reg[g].func;

        always_ff @(posedge clock) begin
            if (reset) begin
                lu_fwd_reg[g].valid <= 1'b0;
            end else begin
                lu_fwd_reg[g].valid <= lu_reg[g].valid;
            end
            if (lu_reg[g].valid) begin
                lu_fwd_reg[g].func       <= lu_reg[g].func;
                lu_fwd_reg[g].addr       <= lu_reg[g].addr;
                lu_fwd_reg[g].prn        <= lu_reg[g].prn;
                lu_fwd_reg[g].robn       <= lu_reg[g].robn;
                lu_fwd_reg[g].tail_store <= lu_reg[g].tail_store;
                lu_fwd_reg[g].value      <= sq[g].value;
                lu_fwd_reg[g].fwd_valid  <= sq[g].fwd_valid;
            end
        end

        // request handshake and response match
        assign taken    = grant_valid && grant_idx == lq_idx_bits'(g) && dcache.accept;
        assign resp_hit = dcache.resp_valid && dcache.resp_idx == lq_idx_bits'(g);

        assign need_mem[g]   = entries[g].valid && entries[g].state == no_forward && !req_sent;
        assign entry_addr[g] = entries[g].addr;

        // entry stage
        always_ff @(posedge clock) begin
            if (reset) begin
                entries[g].valid <= 1'b0;
                req_sent         <= 1'b0;
            end else begin
                if (lu_fwd_reg[g].valid) begin
                    entries[g].valid <= 1'b1;
                    entries[g].state <= lu_fwd_reg[g].fwd_valid ? known : no_forward;
                end else if (result_valid[g] && cdb_grant[g]) begin
                    entries[g].valid <= 1'b0;
                end else if (resp_hit) begin
                    entries[g].state <= known;
                end
                // drops need_mem once memory took the request
                if (lu_fwd_reg[g].valid) begin
                    req_sent <= 1'b0;
                end else if (taken) begin
                    req_sent <= 1'b1;
                end
            end
        end

        always_ff @(posedge clock) begin
            if (lu_fwd_reg[g].valid) begin
                entries[g].func <= lu_fwd_reg[g].func;
                entries[g].addr <= lu_fwd_reg[g].addr;
                entries[g].prn  <= lu_fwd_reg[g].prn;
                entries[g].robn <= lu_fwd_reg[g].robn;
                // forwarded bytes back to their lane, sign_align shifts them down again
                entries[g].data <= lu_fwd_reg[g].value << {lu_fwd_reg[g].addr[1:0], 3'b000};
            end else if (resp_hit) begin
                entries[g].data <= dcache.resp_data;
            end
        end

        // completion outputs
        assign result_valid[g] = entries[g].valid && entries[g].state == known;
        assign result_robn[g]  = entries[g].robn;
        assign result_prn[g]   = entries[g].prn;

        sign_align sign_align_inst (
            .data (entries[g].data),
            .addr (entries[g].addr[1:0]),
            .func (entries[g].func),
            .out  (result_data[g])
        );
    end

endmodule

// File: verilog/load_unit_top.sv
`timescale 1ns/1ps

module load_unit_top (
    input  logic                                                      clock,
    input  logic                                                      reset,
    input  logic [lsq_pkg::num_fu_load-1:0]                           issue_valid,
    input  logic [lsq_pkg::num_fu_load-1:0][lsq_pkg::xlen-1:0]        issue_base,
    input  logic [lsq_pkg::num_fu_load-1:0][11:0]                     issue_offset,
    input  lsq_pkg::mem_func_t [lsq_pkg::num_fu_load-1:0]             issue_func,
    input  logic [lsq_pkg::num_fu_load-1:0][lsq_pkg::prn_bits-1:0]    issue_prn,
    input  logic [lsq_pkg::num_fu_load-1:0][lsq_pkg::robn_bits-1:0]   issue_robn,
    input  logic [lsq_pkg::num_fu_load-1:0][lsq_pkg::sq_idx_bits-1:0] issue_tail_store,
    output logic [lsq_pkg::num_fu_load-1:0]                           rs_ready,
    input  logic [lsq_pkg::num_fu_load-1:0]                           cdb_grant,
    output logic [lsq_pkg::num_fu_load-1:0]                           result_valid,
    output logic [lsq_pkg::num_fu_load-1:0][lsq_pkg::robn_bits-1:0]   result_robn,
    output logic [lsq_pkg::num_fu_load-1:0][lsq_pkg::prn_bits-1:0]    result_prn,
    output logic [lsq_pkg::num_fu_load-1:0][lsq_pkg::xlen-1:0]        result_data,
    input  logic                                                      store_write,
    input  logic [lsq_pkg::sq_idx_bits-1:0]                           store_idx,
    input  logic [lsq_pkg::xlen-1:0]                                  store_addr,
    input  logic [lsq_pkg::xlen-1:0]                                  store_data
);
    import lsq_pkg::*;

    logic [num_fu_load-1:0]           need_mem;
    logic [num_fu_load-1:0][xlen-1:0] entry_addr;
    logic [lq_idx_bits-1:0]           grant_idx;
    logic                             grant_valid;

    sq_fwd_if     sq_fwd [num_fu_load] ();
    dcache_req_if dcache ();

    load_queue load_queue_inst (
        .clock, .reset,
        .issue_valid, .issue_base, .issue_offset, .issue_func,
        .issue_prn, .issue_robn, .issue_tail_store, .rs_ready,
        .cdb_grant, .result_valid, .result_robn, .result_prn, .result_data,
        .sq (sq_fwd),
        .need_mem, .entry_addr, .grant_idx, .grant_valid,
        .dcache (dcache)
    );

    store_queue store_queue_inst (
        .clock, .reset, .store_write, .store_idx, .store_addr, .store_data,
        .sq (sq_fwd)
    );

    load_arbiter load_arbiter_inst (
        .need_mem, .entry_addr, .grant_idx, .grant_valid,
        .dcache (dcache)
    );

    data_memory data_memory_inst (
        .clock, .reset,
        .dcache (dcache)
    );

endmodule

// File: sim/load_unit_asserts.sv
`timescale 1ns/1ps

module load_unit_asserts (
    input logic                              clock,
    input logic                              reset,
    input logic [lsq_pkg::num_fu_load-1:0]   result_valid,
    dcache_req_if                            dcache
);
    import lsq_pkg::*;

    // taken request answers mem_latency cycles later on the same slot
    resp_follows_req: assert property (@(posedge clock) disable iff (reset)
            dcache.req_valid && dcache.accept |-> ##mem_latency
            (dcache.resp_valid && dcache.resp_idx == $past(dcache.req_idx, mem_latency)))
        else $error("memory response missing or on the wrong slot");

    // no response without a request
    resp_has_req: assert property (@(posedge clock) disable iff (reset)
            dcache.resp_valid |-> $past(dcache.req_valid && dcache.accept, mem_latency))
        else $error("memory response without a taken request");

    // first reset edge clears the entries, quiet from then on
    no_req_in_reset: assert property (@(posedge clock)
            reset && $past(reset) |-> !dcache.req_valid)
        else $error("memory request during reset");

    no_resp_in_reset: assert property (@(posedge clock) reset |=> !dcache.resp_valid)
        else $error("memory response right after a reset cycle");

    no_result_in_reset: assert property (@(posedge clock)
            reset && $past(reset) |-> result_valid == '0)
        else $error("load result valid during reset");

endmodule

// File: sim/load_unit_tb.sv
`timescale 1ns/1ps

module load_unit_tb;
    import lsq_pkg::*;

    localparam int sweep_rounds  = 20;
    localparam int random_rounds = 180;
    localparam int total_loads   = (sweep_rounds + random_rounds) * num_fu_load;
    localparam int reset_cycles  = 16;
    // twelve cycles per load covers memory latency plus grant stalls
    localparam int cycle_limit   = total_loads * 12 + reset_cycles;

    logic                                    clock;
    logic                                    reset;
    logic [num_fu_load-1:0]                  issue_valid;
    logic [num_fu_load-1:0][xlen-1:0]        issue_base;
    logic [num_fu_load-1:0][11:0]            issue_offset;
    mem_func_t [num_fu_load-1:0]             issue_func;
    logic [num_fu_load-1:0][prn_bits-1:0]    issue_prn;
    logic [num_fu_load-1:0][robn_bits-1:0]   issue_robn;
    logic [num_fu_load-1:0][sq_idx_bits-1:0] issue_tail_store;
    logic [num_fu_load-1:0]                  rs_ready;
    logic [num_fu_load-1:0]                  cdb_grant;
    logic [num_fu_load-1:0]                  result_valid;
    logic [num_fu_load-1:0][robn_bits-1:0]   result_robn;
    logic [num_fu_load-1:0][prn_bits-1:0]    result_prn;
    logic [num_fu_load-1:0][xlen-1:0]        result_data;
    logic                                    store_write;
    logic [sq_idx_bits-1:0]                  store_idx;
    logic [xlen-1:0]                         store_addr;
    logic [xlen-1:0]                         store_data;

    // reference copy of the store queue
    logic            st_valid [sq_size];
    logic [xlen-1:0] st_addr  [sq_size];
    logic [xlen-1:0] st_data  [sq_size];
    // expected completion per slot
    logic [xlen-1:0]      exp_data [num_fu_load];
    logic [robn_bits-1:0] exp_robn [num_fu_load];
    logic [prn_bits-1:0]  exp_prn  [num_fu_load];
    logic [31:0]          rng;
    int                   cycles;

    load_unit_top load_unit_top_inst (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // memory rule, youngest older store overrides, then size and sign
    function automatic logic [xlen-1:0] expected_load(input logic [xlen-1:0] addr,
            input mem_func_t func, input logic [sq_idx_bits-1:0] tail);
        logic [xlen-1:0] word;
        logic [xlen-1:0] lane;
        word = {~addr[17:2], addr[17:2]};
        for (int i = 0; i < sq_size; i++) begin
            if (st_valid[i] && i < int'(tail) && st_addr[i][xlen-1:2] == addr[xlen-1:2]) begin
                word = st_data[i];
            end
        end
        lane = word >> (8 * addr[1:0]);
        case (func)
            mem_byte:  return {{24{lane[7]}}, lane[7:0]};
            mem_byteu: return {24'h0, lane[7:0]};
            mem_half:  return {{16{lane[15]}}, lane[15:0]};
            mem_halfu: return {16'h0, lane[15:0]};
            default:   return lane;
        endcase
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    // next falling edge, with a fresh grant pattern (stall about one cycle in four)
    task automatic step();
        @(negedge clock);
        rng = xorshift(rng);
        cdb_grant = {rng[5:4] != 2'b00, rng[1:0] != 2'b00};
    endtask

    task automatic write_store(input logic [2:0] idx, input logic [31:0] addr,
            input logic [31:0] data);
        step();
        store_write = 1'b1;
        store_idx   = idx;
        store_addr  = addr;
        store_data  = data;
        st_valid[idx] = 1'b1;
        st_addr[idx]  = addr;
        st_data[idx]  = data;
    endtask

    // base chosen so that base plus sign-extended offset lands on addr
    task automatic drive_slot(input int s, input logic [31:0] addr, input mem_func_t func,
            input logic [2:0] tail);
        rng = xorshift(rng);
        issue_valid[s]      = 1'b1;
        issue_offset[s]     = rng[11:0];
        issue_base[s]       = addr - {{20{rng[11]}}, rng[11:0]};
        issue_func[s]       = func;
        issue_prn[s]        = rng[17:12];
        issue_robn[s]       = rng[22:18];
        issue_tail_store[s] = tail;
        exp_data[s] = expected_load(addr, func, tail);
        exp_prn[s]  = rng[17:12];
        exp_robn[s] = rng[22:18];
    endtask

    // one load per slot in the same cycle, then wait for both to retire
    task automatic run_round(input logic [31:0] a0, input mem_func_t f0, input logic [2:0] t0,
            input logic [31:0] a1, input mem_func_t f1, input logic [2:0] t1);
        step();
        store_write = 1'b0;
        drive_slot(0, a0, f0, t0);
        drive_slot(1, a1, f1, t1);
        step();
        issue_valid = '0;
        while (rs_ready != '1) begin
            step();
        end
    endtask

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            fail_run("timeout, the loads did not all complete within the cycle limit");
        end
    end

    after_reset: assert property (@(posedge clock) $fell(reset) |->
            rs_ready == '1 && result_valid == '0)
        else fail_run($sformatf("ERR rs_ready/result_valid after reset got %h/%h",
            $sampled(rs_ready), $sampled(result_valid)));

    for (genvar g = 0; g < num_fu_load; g++) begin : check
        data_ok: assert property (@(posedge clock) disable iff (reset)
                result_valid[g] && cdb_grant[g] |-> result_data[g] == exp_data[g])
            else fail_run($sformatf("ERR result_data[%0d] got %h expected %h", g,
                $sampled(result_data[g]), $sampled(exp_data[g])));
        robn_ok: assert property (@(posedge clock) disable iff (reset)
                result_valid[g] && cdb_grant[g] |-> result_robn[g] == exp_robn[g])
            else fail_run($sformatf("ERR result_robn[%0d] got %h expected %h", g,
                $sampled(result_robn[g]), $sampled(exp_robn[g])));
        prn_ok: assert property (@(posedge clock) disable iff (reset)
                result_valid[g] && cdb_grant[g] |-> result_prn[g] == exp_prn[g])
            else fail_run($sformatf("ERR result_prn[%0d] got %h expected %h", g,
                $sampled(result_prn[g]), $sampled(exp_prn[g])));
        // a stalled result holds and keeps the slot busy
        stall_hold: assert property (@(posedge clock) disable iff (reset)
                result_valid[g] && !cdb_grant[g] |=> result_valid[g] && !rs_ready[g]
                && $stable(result_data[g]) && $stable(result_robn[g]) && $stable(result_prn[g]))
            else fail_run($sformatf("slot %0d result changed during a completion stall", g));
        // slot frees up only by retiring its result
        retire_on_grant: assert property (@(posedge clock) disable iff (reset)
                $rose(rs_ready[g]) |-> $past(result_valid[g] && cdb_grant[g]))
            else fail_run($sformatf("slot %0d became ready without retiring a result", g));
    end

    initial begin
        rng         = 32'h88e6;
        cycles      = 0;
        reset       = 1'b1;
        issue_valid = '0;
        issue_base  = '0;
        issue_offset = '0;
        issue_prn   = '0;
        issue_robn  = '0;
        issue_tail_store = '0;
        cdb_grant   = '0;
        store_write = 1'b0;
        store_idx   = '0;
        store_addr  = '0;
        store_data  = '0;
        for (int s = 0; s < num_fu_load; s++) begin
            issue_func[s] = mem_word;
        end
        for (int i = 0; i < sq_size; i++) begin
            st_valid[i] = 1'b0;
        end
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        // every function at every byte offset, tail 0 so memory answers
        for (int f = 0; f < 5; f++) begin
            for (int b = 0; b < 4; b++) begin
                rng = xorshift(rng);
                run_round({rng[31:2], 2'(b)}, mem_func_t'(f), 3'd0,
                    {rng[31:2], 2'(b)} ^ 32'h40, mem_func_t'(f), 3'd0);
            end
        end
        // small address pool so stores and loads collide often
        for (int r = 0; r < random_rounds; r++) begin
            rng = xorshift(rng);
            for (int k = 0; k < int'(rng[1:0]); k++) begin
                write_store(rng[4:2] + 3'(k), 32'h1000 + {26'h0, rng[10:5] ^ 6'(k * 13)},
                    xorshift(rng + k));
            end
            rng = xorshift(rng);
            run_round(32'h1000 + {26'h0, rng[5:0]}, mem_func_t'(3'(rng[15:8] % 5)), rng[18:16],
                32'h1000 + {26'h0, rng[24:19]}, mem_func_t'(3'(rng[31:25] % 5)),
                3'(rng[7:6] * 3));
        end
        repeat (4) step();
        $display("Everything OK");
        $finish;
    end

endmodule

bind load_unit_top load_unit_asserts load_unit_asserts_inst (
    .clock        (clock),
    .reset        (reset),
    .result_valid (result_valid),
    .dcache       (dcache)
);

// File: flist.f
verilog/lsq_pkg.sv
verilog/lsq_ifs.sv
verilog/sign_align.sv
verilog/load_arbiter.sv
verilog/store_queue.sv
verilog/data_memory.sv
verilog/load_queue.sv
verilog/load_unit_top.sv
sim/load_unit_asserts.sv
sim/load_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the load unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module load_unit_tb -f flist.f -o load_unit_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/load_unit_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi
exit 0
